//--- design/slice_pkg.sv
// --------------------------------------
// slice controller shared definitions
// slice geometry, memory command codes,
// scheduler state encoding, read beat view
// --------------------------------------
`default_nettype none

package slice_pkg;

	// --------------------------------------
	// slice geometry
	// --------------------------------------
	// 16 beats of 128 bits per slice
	localparam int BEATS_PER_SLICE = 16;
	localparam int BEAT_IDX_W      = 4;
	localparam int DATA_W          = 128;
	localparam int SADDR_W         = 16;
	// host side readout word
	localparam int WORD_W          = 32;
	// memory address is {5'b0, slice, beat, 3'b0}
	localparam int APP_ADDR_W      = 28;

	// memory controller user interface commands
	localparam logic [2:0] CMD_WRITE = 3'b000;
	localparam logic [2:0] CMD_READ  = 3'b001;

	// one-hot scheduler states
	typedef enum logic [4:0] {
		IDLE    = 5'b00001,
		WR      = 5'b00010,
		WR_TURN = 5'b00100,
		RD      = 5'b01000,
		RD_TURN = 5'b10000
	} sched_state_t;

	// returned beat, stored as a line and read out as words
	// word 3 is the most significant
	typedef union packed {
		logic [DATA_W-1:0]            line;
		logic [3:0][WORD_W-1:0]       word;
	} rd_beat_u;

endpackage

`default_nettype wire

//--- design/slice_wr_fifo.sv
// --------------------------------------
// write side slice FIFO
// show-ahead head word, fill level, full flag
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_wr_fifo
	import slice_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
)
(
	input  wire                          I_ddr_clk,
	input  wire                          I_ddr_rst,
	input  wire  [143:0]                 wr_data,
	input  wire                          wr_en,
	input  wire                          rd_en,
	output logic [143:0]                 rd_data,
	output logic [$clog2(FIFO_DEPTH):0]  level,
	output logic                         full
);

	localparam int PTR_W  = $clog2(FIFO_DEPTH);
	localparam int WORD_W_FIFO = DATA_W + SADDR_W;

	logic [WORD_W_FIFO-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;

	// depth has to hold a whole slice
	if (FIFO_DEPTH < BEATS_PER_SLICE || (1 << PTR_W) != FIFO_DEPTH)
	begin : g_depth_check
		$error("FIFO_DEPTH must be a power of two of at least BEATS_PER_SLICE");
	end

	// storage
	always_ff @(posedge I_ddr_clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointers and fill counter
	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			level <= level + {{PTR_W{1'b0}}, wr_en} - {{PTR_W{1'b0}}, rd_en};
		end
	end

	// show-ahead head
	assign rd_data = mem[rd_ptr];
	// msb of level set only at exactly FIFO_DEPTH entries
	assign full    = level[PTR_W];

	// host obeys full, feed pops only buffered words
	a_no_overflow: assert property (@(posedge I_ddr_clk) disable iff (I_ddr_rst)
		!(wr_en && full) && !(rd_en && level == '0));

endmodule

`default_nettype wire

//--- design/slice_sched.sv
// --------------------------------------
// burst scheduler
// read request latch, write trigger,
// one-hot write/read/turnaround FSM
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_sched
	import slice_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
)
(
	input  wire                          I_ddr_clk,
	input  wire                          I_ddr_rst,
	input  wire  [$clog2(FIFO_DEPTH):0]  fifo_level,
	input  wire                          rd_req,
	input  wire  [14:0]                  rd_id,
	input  wire  [1:0]                   xgmii_num,
	input  wire                          cmd_done,
	input  wire                          wdf_done,
	output sched_state_t                 state,
	output logic [14:0]                  rd_id_q,
	output logic [1:0]                   xgmii_num_q
);

	localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

	sched_state_t state_next;
	logic         wr_trig;
	logic         rd_pend;
	logic         cmd_seen;
	logic         wdf_seen;

	// a whole slice is buffered
	assign wr_trig = fifo_level >= LEVEL_W'(BEATS_PER_SLICE);

	// --------------------------------------
	// request latch
	// --------------------------------------
	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			rd_pend <= 1'b0;
		end
		else
		begin
			// consumed on the way into RD
			if (state == IDLE && !wr_trig)
			begin
				rd_pend <= 1'b0;
			end
			if (rd_req)
			begin
				rd_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge I_ddr_clk)
	begin
		if (rd_req)
		begin
			rd_id_q     <= rd_id;
			xgmii_num_q <= xgmii_num;
		end
	end

	// --------------------------------------
	// state machine
	// --------------------------------------
	// both generators have to finish a write burst
	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst || state != WR)
		begin
			cmd_seen <= 1'b0;
			wdf_seen <= 1'b0;
		end
		else
		begin
			cmd_seen <= cmd_seen | cmd_done;
			wdf_seen <= wdf_seen | wdf_done;
		end
	end

	always_comb
	begin
		state_next = state;
		unique case (state)
			IDLE:
			begin
				// writes win
				if (wr_trig)
				begin
					state_next = WR;
				end
				else if (rd_pend)
				begin
					state_next = RD;
				end
			end
			WR:
			begin
				if ((cmd_seen | cmd_done) && (wdf_seen | wdf_done))
				begin
					state_next = WR_TURN;
				end
			end
			RD:
			begin
				if (cmd_done)
				begin
					state_next = RD_TURN;
				end
			end
			default:
			begin
				// one turnaround cycle
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	a_state_onehot: assert property (@(posedge I_ddr_clk) disable iff (I_ddr_rst)
		$onehot(state));
	// host never stacks a second request
	a_single_req: assert property (@(posedge I_ddr_clk) disable iff (I_ddr_rst)
		rd_req |-> !rd_pend);

endmodule

`default_nettype wire

//--- design/slice_wdf_feed.sv
// --------------------------------------
// write data feed
// FIFO pop, holding register on the wdf
// channel, slice address capture
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_wdf_feed
	import slice_pkg::*;
(
	input  wire                 I_ddr_clk,
	input  wire                 I_ddr_rst,
	input  wire  sched_state_t  state,
	input  wire  [143:0]        fifo_data,
	output logic                fifo_pop,
	input  wire                 app_wdf_rdy,
	output logic                app_wdf_wren,
	output logic                app_wdf_end,
	output logic [127:0]        app_wdf_data,
	output logic [15:0]         saddr,
	output logic                saddr_valid,
	output logic                wdf_done
);

	// pops issued, msb set after the 16th
	logic [BEAT_IDX_W:0]   pop_cnt;
	// beats accepted by the memory controller
	logic [BEAT_IDX_W-1:0] beat_cnt;
	logic                  in_wr;
	logic                  load_ok;
	logic                  beat_acc;

	assign in_wr    = state == WR;
	// holding register empty or draining this cycle
	assign load_ok  = !app_wdf_wren || app_wdf_rdy;
	assign fifo_pop = in_wr && !pop_cnt[BEAT_IDX_W] && load_ok;
	assign beat_acc = app_wdf_wren && app_wdf_rdy;
	// every beat is a full burst of one
	assign app_wdf_end = app_wdf_wren;

	// --------------------------------------
	// control
	// --------------------------------------
	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			pop_cnt      <= '0;
			beat_cnt     <= '0;
			app_wdf_wren <= 1'b0;
			saddr_valid  <= 1'b0;
			wdf_done     <= 1'b0;
		end
		else
		begin
			// first word of the slice carries the address
			saddr_valid <= fifo_pop && (pop_cnt == '0);
			wdf_done    <= beat_acc && (beat_cnt == '1);
			if (!in_wr)
			begin
				pop_cnt  <= '0;
				beat_cnt <= '0;
			end
			else
			begin
				if (fifo_pop)
				begin
					pop_cnt <= pop_cnt + 1'b1;
				end
				if (beat_acc)
				begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end
			if (fifo_pop)
			begin
				app_wdf_wren <= 1'b1;
			end
			else if (app_wdf_rdy)
			begin
				app_wdf_wren <= 1'b0;
			end
		end
	end

	// payload
	always_ff @(posedge I_ddr_clk)
	begin
		if (fifo_pop)
		begin
			app_wdf_data <= fifo_data[DATA_W-1:0];
		end
		if (fifo_pop && pop_cnt == '0)
		begin
			saddr <= fifo_data[DATA_W +: SADDR_W];
		end
	end

	a_wdf_hold: assert property (@(posedge I_ddr_clk) disable iff (I_ddr_rst)
		app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data));

endmodule

`default_nettype wire

//--- design/slice_cmd_gen.sv
// --------------------------------------
// command generator
// 16 write or read commands per burst,
// slice address plus beat index
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_cmd_gen
	import slice_pkg::*;
(
	input  wire                 I_ddr_clk,
	input  wire                 I_ddr_rst,
	input  wire  sched_state_t  state,
	input  wire  [15:0]         saddr,
	input  wire                 saddr_valid,
	input  wire  [14:0]         rd_id_q,
	input  wire  [1:0]          xgmii_num_q,
	input  wire                 app_rdy,
	output logic [2:0]          app_cmd,
	output logic                app_en,
	output logic [27:0]         app_addr,
	output logic                cmd_done
);

	// burst already launched in this state
	logic                  started;
	logic                  start_wr;
	logic                  start_rd;
	logic [BEAT_IDX_W-1:0] beat_idx;
	logic [SADDR_W-1:0]    slice_addr;

	// write waits for the slice address from the feed
	assign start_wr = (state == WR) && saddr_valid && !started;
	assign start_rd = (state == RD) && !started;

	// 5 zero bits, slice, beat, 3 zero bits
	assign app_addr = {5'b0, slice_addr, beat_idx, 3'b000};

	// --------------------------------------
	// command sequencing
	// --------------------------------------
	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			started  <= 1'b0;
			app_en   <= 1'b0;
			app_cmd  <= CMD_WRITE;
			beat_idx <= '0;
			cmd_done <= 1'b0;
		end
		else
		begin
			cmd_done <= 1'b0;
			if (start_wr || start_rd)
			begin
				started  <= 1'b1;
				app_en   <= 1'b1;
				beat_idx <= '0;
				app_cmd  <= start_rd ? CMD_READ : CMD_WRITE;
			end
			else if (app_en && app_rdy)
			begin
				// accepted, advance or finish
				if (beat_idx == '1)
				begin
					app_en   <= 1'b0;
					cmd_done <= 1'b1;
				end
				else
				begin
					beat_idx <= beat_idx + 1'b1;
				end
			end
			// rearm once the burst state is left
			if (state != WR && state != RD)
			begin
				started <= 1'b0;
			end
		end
	end

	// slice address, read side maps port onto the top bits
	always_ff @(posedge I_ddr_clk)
	begin
		if (start_wr)
		begin
			slice_addr <= saddr;
		end
		else if (start_rd)
		begin
			slice_addr <= {xgmii_num_q, rd_id_q[13:0]};
		end
	end

	a_cmd_hold: assert property (@(posedge I_ddr_clk) disable iff (I_ddr_rst)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr));

endmodule

`default_nettype wire

//--- design/slice_rd_buf.sv
// --------------------------------------
// read capture buffer
// 16 beat store, response pulse,
// 32-bit word readout pipeline
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_rd_buf
	import slice_pkg::*;
(
	input  wire          I_ddr_clk,
	input  wire          I_ddr_rst,
	input  wire  [127:0] app_rd_data,
	input  wire          app_rd_data_valid,
	output logic         rd_resp,
	input  wire          rd_en,
	output logic [31:0]  rd_data
);

	rd_beat_u              mem [BEATS_PER_SLICE];
	logic [BEAT_IDX_W-1:0] wr_ptr;
	logic                  last_beat;

	// readout index, beat in the top bits, word in the low two
	logic [BEAT_IDX_W+1:0] rd_cnt;
	rd_beat_u              beat_q;
	logic [1:0]            word_sel_q;

	// --------------------------------------
	// capture side
	// --------------------------------------
	always_ff @(posedge I_ddr_clk)
	begin
		if (app_rd_data_valid)
		begin
			mem[wr_ptr].line <= app_rd_data;
		end
	end

	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			wr_ptr    <= '0;
			last_beat <= 1'b0;
			rd_resp   <= 1'b0;
		end
		else
		begin
			if (app_rd_data_valid)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// 16th beat seen, response one cycle later
			last_beat <= app_rd_data_valid && (wr_ptr == '1);
			rd_resp   <= last_beat;
		end
	end

	// --------------------------------------
	// readout side
	// --------------------------------------
	always_ff @(posedge I_ddr_clk)
	begin
		if (I_ddr_rst)
		begin
			rd_cnt <= '0;
		end
		else if (rd_en)
		begin
			// wraps to zero after 64 words
			rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// stage 1 beat fetch, stage 2 word pick
	always_ff @(posedge I_ddr_clk)
	begin
		beat_q     <= mem[rd_cnt[BEAT_IDX_W+1:2]];
		word_sel_q <= rd_cnt[1:0];
		// most significant word first
		rd_data    <= beat_q.word[2'd3 - word_sel_q];
	end

endmodule

`default_nettype wire

//--- design/slice_ddr_ctrl.sv
// --------------------------------------
// DDR slice controller top level
// slice FIFO, scheduler, write feed,
// command generator, read buffer
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_ddr_ctrl
	import slice_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
)
(
	input  wire          I_ddr_clk,
	input  wire          I_ddr_rst,
	// slice input
	input  wire  [143:0] wr_data,
	input  wire          wr_en,
	output logic         wr_full,
	// read request and readout
	input  wire          rd_req,
	input  wire  [14:0]  rd_id,
	input  wire  [1:0]   xgmii_num,
	output logic         rd_resp,
	input  wire          rd_en,
	output logic [31:0]  rd_data,
	// memory controller user interface
	output logic [2:0]   app_cmd,
	output logic         app_en,
	output logic [27:0]  app_addr,
	input  wire          app_rdy,
	output logic         app_wdf_wren,
	output logic         app_wdf_end,
	output logic [127:0] app_wdf_data,
	input  wire          app_wdf_rdy,
	input  wire  [127:0] app_rd_data,
	input  wire          app_rd_data_valid
);

	logic [$clog2(FIFO_DEPTH):0] fifo_level;
	logic [143:0]                fifo_head;
	logic                        fifo_pop;
	sched_state_t                state;
	logic [14:0]                 rd_id_q;
	logic [1:0]                  xgmii_num_q;
	logic [15:0]                 saddr;
	logic                        saddr_valid;
	logic                        wdf_done;
	logic                        cmd_done;

	// --------------------------------------
	// write buffering and scheduling
	// --------------------------------------
	slice_wr_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) slice_wr_fifo_inst (
		.I_ddr_clk (I_ddr_clk),
		.I_ddr_rst (I_ddr_rst),
		.wr_data   (wr_data),
		.wr_en     (wr_en),
		.rd_en     (fifo_pop),
		.rd_data   (fifo_head),
		.level     (fifo_level),
		.full      (wr_full)
	);

	slice_sched #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) slice_sched_inst (
		.I_ddr_clk   (I_ddr_clk),
		.I_ddr_rst   (I_ddr_rst),
		.fifo_level  (fifo_level),
		.rd_req      (rd_req),
		.rd_id       (rd_id),
		.xgmii_num   (xgmii_num),
		.cmd_done    (cmd_done),
		.wdf_done    (wdf_done),
		.state       (state),
		.rd_id_q     (rd_id_q),
		.xgmii_num_q (xgmii_num_q)
	);

	// --------------------------------------
	// memory controller side
	// --------------------------------------
	slice_wdf_feed slice_wdf_feed_inst (
		.I_ddr_clk    (I_ddr_clk),
		.I_ddr_rst    (I_ddr_rst),
		.state        (state),
		.fifo_data    (fifo_head),
		.fifo_pop     (fifo_pop),
		.app_wdf_rdy  (app_wdf_rdy),
		.app_wdf_wren (app_wdf_wren),
		.app_wdf_end  (app_wdf_end),
		.app_wdf_data (app_wdf_data),
		.saddr        (saddr),
		.saddr_valid  (saddr_valid),
		.wdf_done     (wdf_done)
	);

	slice_cmd_gen slice_cmd_gen_inst (
		.I_ddr_clk   (I_ddr_clk),
		.I_ddr_rst   (I_ddr_rst),
		.state       (state),
		.saddr       (saddr),
		.saddr_valid (saddr_valid),
		.rd_id_q     (rd_id_q),
		.xgmii_num_q (xgmii_num_q),
		.app_rdy     (app_rdy),
		.app_cmd     (app_cmd),
		.app_en      (app_en),
		.app_addr    (app_addr),
		.cmd_done    (cmd_done)
	);

	// returned beats straight from the ports
	slice_rd_buf slice_rd_buf_inst (
		.I_ddr_clk         (I_ddr_clk),
		.I_ddr_rst         (I_ddr_rst),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.rd_resp           (rd_resp),
		.rd_en             (rd_en),
		.rd_data           (rd_data)
	);

endmodule

`default_nettype wire

//--- test/slice_ddr_ctrl_tb.sv
// --------------------------------------
// slice controller testbench
// memory controller model with random stalls,
// directed write, read, stall and priority tests,
// watchdog
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slice_ddr_ctrl_tb
	import slice_pkg::*;
;

	// about 700 cycles of traffic, plenty of margin
	localparam int WATCHDOG_NS   = 20000;
	localparam int BURST_TIMEOUT = 500;

	logic          clk;
	logic          rst;
	logic [143:0]  wr_data;
	logic          wr_en;
	logic          wr_full;
	logic          rd_req;
	logic [14:0]   rd_id;
	logic [1:0]    xgmii_num;
	logic          rd_resp;
	logic          rd_en;
	logic [31:0]   rd_data;
	logic [2:0]    app_cmd;
	logic          app_en;
	logic [27:0]   app_addr;
	logic          app_rdy = 1'b1;
	logic          app_wdf_wren;
	logic          app_wdf_end;
	logic [127:0]  app_wdf_data;
	logic          app_wdf_rdy = 1'b1;
	logic [127:0]  app_rd_data = '0;
	logic          app_rd_data_valid = 1'b0;

	// --------------------------------------
	// bookkeeping
	// --------------------------------------
	int            errors = 0;
	int            checks = 0;
	int            mon_errors = 0;
	int            mon_checks = 0;
	logic [31:0]   data_seed = 32'he667;
	logic [31:0]   stall_seed = 32'he667;
	logic          stall_en = 1'b0;
	logic [127:0]  cur_data [BEATS_PER_SLICE];

	// memory model state
	logic [127:0]  ddr_mem [logic [27:0]];
	logic [27:0]   waddr_pend [$];
	logic [127:0]  wdata_pend [$];
	int            ret_due [$];
	logic [127:0]  ret_data [$];
	int            cyc = 0;

	// observed traffic, never cleared, tests keep base indices
	logic [2:0]    cmd_log [$];
	logic [27:0]   addr_log [$];
	logic [127:0]  wdata_log [$];
	int            cmd_base;
	int            wdat_base;
	int            resp_base;
	int            word_base;

	// readout monitor
	logic [31:0]   exp_words [$];
	logic [31:0]   exp_w;
	logic          en_d1 = 1'b0;
	logic          en_d2 = 1'b0;
	int            neg_cnt = 0;
	int            ret_total = 0;
	int            last_ret_neg = 0;
	int            resp_total = 0;
	int            words_seen = 0;
	logic          rd_cmd;

	slice_ddr_ctrl #(
		.FIFO_DEPTH (64)
	) slice_ddr_ctrl_inst (
		.I_ddr_clk         (clk),
		.I_ddr_rst         (rst),
		.wr_data           (wr_data),
		.wr_en             (wr_en),
		.wr_full           (wr_full),
		.rd_req            (rd_req),
		.rd_id             (rd_id),
		.xgmii_num         (xgmii_num),
		.rd_resp           (rd_resp),
		.rd_en             (rd_en),
		.rd_data           (rd_data),
		.app_cmd           (app_cmd),
		.app_en            (app_en),
		.app_addr          (app_addr),
		.app_rdy           (app_rdy),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_data_word();
		data_seed = lcg_step(data_seed);
		return data_seed;
	endfunction

	// --------------------------------------
	// memory controller model
	// --------------------------------------
	// sampled at the falling edge, values held until the next rising edge
	task automatic sample_bus();
		neg_cnt = neg_cnt + 1;
		rd_cmd  = 1'b0;
		if (app_wdf_wren && app_wdf_rdy)
		begin
			wdata_log.push_back(app_wdf_data);
			wdata_pend.push_back(app_wdf_data);
			mon_checks = mon_checks + 1;
			if (app_wdf_end !== 1'b1)
			begin
				mon_errors = mon_errors + 1;
				$display("[FAIL] app_wdf_end got %h exp 1", app_wdf_end);
			end
		end
		if (app_en && app_rdy)
		begin
			cmd_log.push_back(app_cmd);
			addr_log.push_back(app_addr);
			if (app_cmd == CMD_WRITE)
			begin
				waddr_pend.push_back(app_addr);
			end
			else
			begin
				rd_cmd = 1'b1;
			end
		end
		// pair write addresses with write beats in arrival order
		while (waddr_pend.size() > 0 && wdata_pend.size() > 0)
		begin
			ddr_mem[waddr_pend.pop_front()] = wdata_pend.pop_front();
		end
		if (rd_cmd)
		begin
			ret_due.push_back(cyc + 4);
			if (ddr_mem.exists(app_addr))
			begin
				ret_data.push_back(ddr_mem[app_addr]);
			end
			else
			begin
				ret_data.push_back('0);
			end
		end
		// response timing against the 16th returned beat
		if (app_rd_data_valid)
		begin
			ret_total = ret_total + 1;
			if (ret_total % BEATS_PER_SLICE == 0)
			begin
				last_ret_neg = neg_cnt;
			end
		end
		if (rd_resp)
		begin
			resp_total = resp_total + 1;
			mon_checks = mon_checks + 1;
			if (neg_cnt - last_ret_neg != 2)
			begin
				mon_errors = mon_errors + 1;
				$display("rd_resp came %0d cycles after the last beat instead of 2",
					neg_cnt - last_ret_neg);
			end
		end
		// readout words two cycles behind rd_en
		if (en_d2)
		begin
			mon_checks = mon_checks + 1;
			if (exp_words.size() == 0)
			begin
				mon_errors = mon_errors + 1;
				$display("rd_data word appeared with no word expected");
			end
			else
			begin
				exp_w = exp_words.pop_front();
				words_seen = words_seen + 1;
				if (rd_data !== exp_w)
				begin
					mon_errors = mon_errors + 1;
					$display("[FAIL] rd_data got %h exp %h", rd_data, exp_w);
				end
			end
		end
		en_d2 = en_d1;
		en_d1 = rd_en;
	endtask

	task automatic drive_response();
		if (stall_en)
		begin
			stall_seed  = lcg_step(stall_seed);
			app_rdy     = stall_seed[17:16] != 2'b00;
			app_wdf_rdy = stall_seed[21:20] != 2'b00;
		end
		else
		begin
			app_rdy     = 1'b1;
			app_wdf_rdy = 1'b1;
		end
		// one returned beat per cycle, in command order
		if (ret_due.size() > 0 && ret_due[0] <= cyc)
		begin
			app_rd_data_valid = 1'b1;
			app_rd_data       = ret_data.pop_front();
			void'(ret_due.pop_front());
		end
		else
		begin
			app_rd_data_valid = 1'b0;
		end
	endtask

	initial
	begin : mem_model
		forever
		begin
			@(negedge clk);
			if (!rst)
			begin
				sample_bus();
			end
			@(posedge clk);
			cyc = cyc + 1;
			#1;
			drive_response();
		end
	end

	// --------------------------------------
	// test tasks
	// --------------------------------------
	task automatic mark_logs();
		cmd_base  = cmd_log.size();
		wdat_base = wdata_log.size();
		resp_base = resp_total;
		word_base = words_seen;
	endtask

	task automatic fill_slice();
		for (int i = 0; i < BEATS_PER_SLICE; i++)
		begin
			cur_data[i] = {next_data_word(), next_data_word(), next_data_word(),
				next_data_word()};
		end
	endtask

	task automatic check_reset_state();
		checks = checks + 1;
		if (app_en || app_wdf_wren || app_wdf_end || rd_resp || wr_full)
		begin
			errors = errors + 1;
			$display("[FAIL] outputs after reset got %h exp 0",
				{app_en, app_wdf_wren, app_wdf_end, rd_resp, wr_full});
		end
	endtask

	// 16 words, optional read request on the last one
	task automatic push_slice(input logic [15:0] sa, input logic with_req,
		input logic [14:0] id, input logic [1:0] port);
		for (int i = 0; i < BEATS_PER_SLICE; i++)
		begin
			@(posedge clk);
			#1;
			while (wr_full)
			begin
				wr_en = 1'b0;
				@(posedge clk);
				#1;
			end
			wr_en     = 1'b1;
			wr_data   = {sa, cur_data[i]};
			rd_req    = with_req && (i == BEATS_PER_SLICE - 1);
			rd_id     = id;
			xgmii_num = port;
		end
		@(posedge clk);
		#1;
		wr_en  = 1'b0;
		rd_req = 1'b0;
	endtask

	task automatic request_read(input logic [14:0] id, input logic [1:0] port);
		@(posedge clk);
		#1;
		rd_req    = 1'b1;
		rd_id     = id;
		xgmii_num = port;
		@(posedge clk);
		#1;
		rd_req = 1'b0;
	endtask

	task automatic check_write_burst(input logic [15:0] sa, input int base);
		int n;
		logic [27:0] ea;
		n = 0;
		while ((cmd_log.size() < base + 16 || wdata_log.size() < wdat_base + 16)
			&& n < BURST_TIMEOUT)
		begin
			@(posedge clk);
			n = n + 1;
		end
		checks = checks + 1;
		if (n >= BURST_TIMEOUT)
		begin
			errors = errors + 1;
			$display("write burst did not complete in time");
			return;
		end
		for (int i = 0; i < BEATS_PER_SLICE; i++)
		begin
			ea = {5'b0, sa, i[3:0], 3'b000};
			checks = checks + 1;
			if (cmd_log[base + i] !== CMD_WRITE)
			begin
				errors = errors + 1;
				$display("[FAIL] app_cmd got %h exp %h", cmd_log[base + i], CMD_WRITE);
			end
			if (addr_log[base + i] !== ea)
			begin
				errors = errors + 1;
				$display("[FAIL] app_addr got %h exp %h", addr_log[base + i], ea);
			end
			if (wdata_log[wdat_base + i] !== cur_data[i])
			begin
				errors = errors + 1;
				$display("[FAIL] app_wdf_data got %h exp %h", wdata_log[wdat_base + i],
					cur_data[i]);
			end
		end
	endtask

	task automatic check_read_burst(input logic [15:0] sa, input int base);
		int n;
		logic [27:0] ea;
		n = 0;
		while ((resp_total < resp_base + 1 || cmd_log.size() < base + 16)
			&& n < BURST_TIMEOUT)
		begin
			@(posedge clk);
			n = n + 1;
		end
		checks = checks + 1;
		if (n >= BURST_TIMEOUT)
		begin
			errors = errors + 1;
			$display("read burst or rd_resp did not arrive in time");
			return;
		end
		for (int i = 0; i < BEATS_PER_SLICE; i++)
		begin
			ea = {5'b0, sa, i[3:0], 3'b000};
			checks = checks + 1;
			if (cmd_log[base + i] !== CMD_READ)
			begin
				errors = errors + 1;
				$display("[FAIL] app_cmd got %h exp %h", cmd_log[base + i], CMD_READ);
			end
			if (addr_log[base + i] !== ea)
			begin
				errors = errors + 1;
				$display("[FAIL] app_addr got %h exp %h", addr_log[base + i], ea);
			end
		end
	endtask

	// 64 words, most significant word of each beat first
	task automatic readout_slice(input int base);
		rd_beat_u beat;
		int n;
		for (int i = 0; i < BEATS_PER_SLICE; i++)
		begin
			beat.line = cur_data[i];
			for (int w = 3; w >= 0; w--)
			begin
				exp_words.push_back(beat.word[w]);
			end
		end
		for (int i = 0; i < 64; i++)
		begin
			@(posedge clk);
			#1;
			rd_en = 1'b1;
		end
		@(posedge clk);
		#1;
		rd_en = 1'b0;
		n = 0;
		while (words_seen < word_base + 64 && n < 16)
		begin
			@(posedge clk);
			n = n + 1;
		end
		repeat (4) @(posedge clk);
		checks = checks + 1;
		if (words_seen != word_base + 64 || exp_words.size() != 0)
		begin
			errors = errors + 1;
			$display("readout gave %0d words instead of 64", words_seen - word_base);
		end
		if (resp_total != resp_base + 1)
		begin
			errors = errors + 1;
			$display("rd_resp pulsed %0d times instead of once", resp_total - resp_base);
		end
		if (cmd_log.size() != base + 16)
		begin
			errors = errors + 1;
			$display("unexpected extra commands after the read burst");
		end
	endtask

	// --------------------------------------
	// test sequence
	// --------------------------------------
	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		wr_data   = '0;
		wr_en     = 1'b0;
		rd_req    = 1'b0;
		rd_id     = '0;
		xgmii_num = '0;
		rd_en     = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		check_reset_state();

		// plain write, then read back through port and id mapping
		fill_slice();
		mark_logs();
		push_slice(16'h9a5c, 1'b0, '0, '0);
		check_write_burst(16'h9a5c, cmd_base);
		repeat (4) @(posedge clk);
		mark_logs();
		// id bit 14 is not part of the slice address
		request_read({1'b1, 14'h1a5c}, 2'b10);
		check_read_burst(16'h9a5c, cmd_base);
		readout_slice(cmd_base);

		// same flow under random ready stalls
		stall_en = 1'b1;
		fill_slice();
		mark_logs();
		push_slice(16'h3c81, 1'b0, '0, '0);
		check_write_burst(16'h3c81, cmd_base);
		repeat (4) @(posedge clk);
		mark_logs();
		request_read({1'b0, 14'h3c81}, 2'b00);
		check_read_burst(16'h3c81, cmd_base);
		readout_slice(cmd_base);
		stall_en = 1'b0;

		// request and full slice pending together, write goes first
		fill_slice();
		mark_logs();
		push_slice(16'h9a5c, 1'b1, {1'b0, 14'h1a5c}, 2'b10);
		check_write_burst(16'h9a5c, cmd_base);
		check_read_burst(16'h9a5c, cmd_base + 16);
		readout_slice(cmd_base + 16);

		repeat (8) @(posedge clk);
		errors = errors + mon_errors;
		checks = checks + mon_checks;
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("run did not finish within %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- slice_ddr_ctrl.f
design/slice_pkg.sv
design/slice_wr_fifo.sv
design/slice_sched.sv
design/slice_wdf_feed.sv
design/slice_cmd_gen.sv
design/slice_rd_buf.sv
design/slice_ddr_ctrl.sv
test/slice_ddr_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the slice controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module slice_ddr_ctrl_tb \
	-f slice_ddr_ctrl.f -o slice_sim
out=$(./obj_dir/slice_sim)
echo "$out"
if echo "$out" | grep -q "^Everything OK$"; then
	exit 0
fi
exit 1
